/* sb_cfg.svh */
// scoreboard configuration: queue depth, port counts and data path widths

`ifndef SB_CFG_SVH
`define SB_CFG_SVH

// --------------------
// queue geometry
// --------------------

// number of queue slots, must stay a power of two
`define SB_NR_ENTRIES 8

// result write-back ports from the functional units
`define SB_NR_WB_PORTS 2

// in-order retire ports towards the commit stage
`define SB_NR_COMMIT_PORTS 2

// --------------------
// data path
// --------------------

// integer register address, 32 architectural registers
`define SB_REG_ADDR_BITS 5

// width of one result word
`define SB_XLEN 32

`endif

/* sb_pkg.sv */
// scoreboard types: unit encoding, slot layout and port bundles

`default_nettype none

`include "sb_cfg.svh"

package sb_pkg;

  // slot index, doubles as transaction id
  typedef logic [$clog2(`SB_NR_ENTRIES)-1:0] trans_id_t;

  // integer register address
  typedef logic [`SB_REG_ADDR_BITS-1:0] reg_addr_t;

  // result word
  typedef logic [`SB_XLEN-1:0] data_t;

  // functional unit that executes an instruction
  // NONE completes without any write-back
  typedef enum logic [2:0] {
    NONE,
    ALU,
    BRANCH,
    LOAD,
    STORE,
    MULT,
    CSR
  } fu_t;

  // one scoreboard entry as seen by issue and commit
  typedef struct packed {
    trans_id_t trans_id;
    fu_t       fu;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    data_t     result;
    // result present
    logic      valid;
  } sb_entry_t;

  // stored form of a queue slot
  typedef struct packed {
    logic      issued;
    sb_entry_t entry;
  } sb_slot_t;

  // result from one functional unit
  typedef struct packed {
    logic      valid;
    trans_id_t trans_id;
    data_t     data;
  } wb_port_t;

  // decoder output with its valid
  typedef struct packed {
    sb_entry_t entry;
    logic      valid;
  } issue_req_t;

endpackage

`default_nettype wire

/* sb_queue_ctrl.sv */
// scoreboard queue control: issue/commit pointers, occupancy and issue handshake

`timescale 1ns/100ps
`default_nettype none

`include "sb_cfg.svh"

module sb_queue_ctrl (
  input  wire logic                                              clk_i,
  input  wire logic                                              rst_ni,
  input  wire logic                                              flush_i,
  input  wire logic                                              dec_valid_i,
  input  wire logic                                              issue_ack_i,
  input  wire logic      [`SB_NR_COMMIT_PORTS-1:0]               commit_ack_i,
  output logic                                                   issue_en_o,
  output sb_pkg::trans_id_t                                      issue_ptr_o,
  output sb_pkg::trans_id_t [`SB_NR_COMMIT_PORTS-1:0]            commit_ptr_o,
  output logic                                                   full_o,
  output logic                                                   issue_valid_o,
  output logic                                                   decoded_ack_o
);
  import sb_pkg::*;

  // wide enough to hold the number of commit acks in one cycle
  localparam int unsigned commit_cnt_w = $clog2(`SB_NR_COMMIT_PORTS) + 1;

  trans_id_t                 issue_ptr_q, issue_ptr_n;
  trans_id_t                 commit_base_q, commit_base_n;
  trans_id_t                 cnt_q, cnt_n;
  logic [commit_cnt_w-1:0]   num_commit;

  // --------------------
  // handshake
  // --------------------
  // count saturates one below the depth, so one slot always stays free
  assign full_o        = (cnt_q == trans_id_t'(`SB_NR_ENTRIES - 1));
  assign issue_valid_o = dec_valid_i & ~full_o;
  assign decoded_ack_o = issue_ack_i & ~full_o;
  // accepted only when both sides agree and no flush is pending
  assign issue_en_o    = dec_valid_i & decoded_ack_o & ~flush_i;

  // number of entries retired this cycle
  always_comb begin : commit_count
    num_commit = '0;
    for (int unsigned k = 0; k < `SB_NR_COMMIT_PORTS; k++) begin
      num_commit = num_commit + commit_cnt_w'(commit_ack_i[k]);
    end
  end

  // --------------------
  // pointer updates
  // --------------------
  // pointers wrap naturally, depth is a power of two
  assign issue_ptr_n   = flush_i ? '0 : issue_ptr_q + trans_id_t'(issue_en_o);
  assign commit_base_n = flush_i ? '0 : commit_base_q + trans_id_t'(num_commit);
  assign cnt_n         = flush_i ? '0 :
                         cnt_q - trans_id_t'(num_commit) + trans_id_t'(issue_en_o);

  always_ff @(posedge clk_i or negedge rst_ni) begin : regs
    if (!rst_ni) begin
      issue_ptr_q   <= '0;
      commit_base_q <= '0;
      cnt_q         <= '0;
    end else begin
      issue_ptr_q   <= issue_ptr_n;
      commit_base_q <= commit_base_n;
      cnt_q         <= cnt_n;
    end
  end

  assign issue_ptr_o = issue_ptr_q;

  // commit port k looks k slots past the oldest entry
  for (genvar k = 0; k < `SB_NR_COMMIT_PORTS; k++) begin : gen_commit_ptr
    assign commit_ptr_o[k] = commit_base_q + trans_id_t'(k);
  end

endmodule

`default_nettype wire

/* sb_entry_store.sv */
// scoreboard entry store: slot array with issue, completion, commit and flush

`timescale 1ns/100ps
`default_nettype none

`include "sb_cfg.svh"

module sb_entry_store (
  input  wire logic                                           clk_i,
  input  wire logic                                           rst_ni,
  input  wire logic                                           flush_i,
  input  wire logic                                           issue_en_i,
  input  wire sb_pkg::trans_id_t                              issue_ptr_i,
  input  wire sb_pkg::sb_entry_t                              issue_entry_i,
  input  wire sb_pkg::wb_port_t  [`SB_NR_WB_PORTS-1:0]        wb_i,
  input  wire logic              [`SB_NR_COMMIT_PORTS-1:0]    commit_ack_i,
  input  wire sb_pkg::trans_id_t [`SB_NR_COMMIT_PORTS-1:0]    commit_ptr_i,
  output sb_pkg::sb_slot_t       [`SB_NR_ENTRIES-1:0]         mem_o
);
  import sb_pkg::*;

  // per-slot state bits
  logic [`SB_NR_ENTRIES-1:0] issued_q, issued_n;
  logic [`SB_NR_ENTRIES-1:0] valid_q, valid_n;

  // instruction payload, only meaningful while the slot is issued
  sb_entry_t [`SB_NR_ENTRIES-1:0] payload_q, payload_n;

  // events applied in order, a later one overrides an earlier one
  always_comb begin : next_state
    issued_n  = issued_q;
    valid_n   = valid_q;
    payload_n = payload_q;

    // --------------------
    // issue
    // --------------------
    if (issue_en_i) begin
      issued_n[issue_ptr_i]        = 1'b1;
      valid_n[issue_ptr_i]         = 1'b0;
      payload_n[issue_ptr_i]       = issue_entry_i;
      payload_n[issue_ptr_i].valid = 1'b0;
    end

    // --------------------
    // self-complete
    // --------------------
    // no unit to wait for, result counts as present one cycle after it appears
    for (int unsigned i = 0; i < `SB_NR_ENTRIES; i++) begin
      if (issued_q[i] && payload_q[i].fu == NONE) begin
        valid_n[i] = 1'b1;
      end
    end

    // --------------------
    // write-back
    // --------------------
    // stale results for slots that were flushed or retired are dropped
    for (int unsigned p = 0; p < `SB_NR_WB_PORTS; p++) begin
      if (wb_i[p].valid && issued_q[wb_i[p].trans_id]) begin
        valid_n[wb_i[p].trans_id]          = 1'b1;
        payload_n[wb_i[p].trans_id].result = wb_i[p].data;
      end
    end

    // --------------------
    // commit
    // --------------------
    for (int unsigned k = 0; k < `SB_NR_COMMIT_PORTS; k++) begin
      if (commit_ack_i[k]) begin
        issued_n[commit_ptr_i[k]] = 1'b0;
        valid_n[commit_ptr_i[k]]  = 1'b0;
      end
    end

    // flush drops everything in flight
    if (flush_i) begin
      issued_n = '0;
      valid_n  = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : state_regs
    if (!rst_ni) begin
      issued_q <= '0;
      valid_q  <= '0;
    end else begin
      issued_q <= issued_n;
      valid_q  <= valid_n;
    end
  end

  always_ff @(posedge clk_i) begin : payload_regs
    payload_q <= payload_n;
  end

  // reassemble the slot view, state bits take the place of the stored flag
  always_comb begin : slot_view
    for (int unsigned i = 0; i < `SB_NR_ENTRIES; i++) begin
      mem_o[i].issued      = issued_q[i];
      mem_o[i].entry       = payload_q[i];
      mem_o[i].entry.valid = valid_q[i];
    end
  end

endmodule

`default_nettype wire

/* sb_clobber.sv */
// scoreboard clobber table: unit that will write each integer register

`timescale 1ns/100ps
`default_nettype none

`include "sb_cfg.svh"

module sb_clobber (
  input  wire sb_pkg::sb_slot_t [`SB_NR_ENTRIES-1:0]          mem_i,
  output sb_pkg::fu_t           [2**`SB_REG_ADDR_BITS-1:0]    rd_clobber_o
);
  import sb_pkg::*;

  // --------------------
  // register lookup
  // --------------------
  // one match search per register
  // walk slots from the top down so the lowest index is written last and wins
  always_comb begin : clobber_lookup
    for (int unsigned r = 0; r < 2**`SB_REG_ADDR_BITS; r++) begin
      rd_clobber_o[r] = NONE;
    end

    // x0 is never clobbered, search starts at register 1
    for (int unsigned r = 1; r < 2**`SB_REG_ADDR_BITS; r++) begin
      for (int i = `SB_NR_ENTRIES - 1; i >= 0; i--) begin
        if (mem_i[i].issued && mem_i[i].entry.rd == reg_addr_t'(r)) begin
          rd_clobber_o[r] = mem_i[i].entry.fu;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* sb_operand_fwd.sv */
// scoreboard operand forwarding: rs1/rs2 from write-back ports or finished slots

`timescale 1ns/100ps
`default_nettype none

`include "sb_cfg.svh"

module sb_operand_fwd (
  input  wire sb_pkg::sb_slot_t [`SB_NR_ENTRIES-1:0]     mem_i,
  input  wire sb_pkg::wb_port_t [`SB_NR_WB_PORTS-1:0]    wb_i,
  input  wire sb_pkg::reg_addr_t                         rs1_i,
  input  wire sb_pkg::reg_addr_t                         rs2_i,
  output sb_pkg::data_t                                  rs1_o,
  output logic                                           rs1_valid_o,
  output sb_pkg::data_t                                  rs2_o,
  output logic                                           rs2_valid_o
);
  import sb_pkg::*;

  // result of one operand lookup
  typedef struct packed {
    logic  valid;
    data_t data;
  } fwd_t;

  fwd_t rs1_fwd;
  fwd_t rs2_fwd;

  // --------------------
  // priority search
  // --------------------
  // candidates scanned lowest priority first, the last hit wins
  // order of priority: wb port 0, wb port 1, finished slots by index
  function automatic fwd_t fwd_read(input reg_addr_t rs,
                                    input sb_slot_t [`SB_NR_ENTRIES-1:0] mem,
                                    input wb_port_t [`SB_NR_WB_PORTS-1:0] wb);
    fwd_t res;
    logic found;
    res   = '0;
    found = 1'b0;

    // finished entries, highest index first
    for (int i = `SB_NR_ENTRIES - 1; i >= 0; i--) begin
      if (mem[i].issued && mem[i].entry.valid && mem[i].entry.rd == rs) begin
        found    = 1'b1;
        res.data = mem[i].entry.result;
      end
    end

    // write-back ports beat any stored result
    // target slot must still be live, otherwise it is a stale write
    for (int p = `SB_NR_WB_PORTS - 1; p >= 0; p--) begin
      if (wb[p].valid && mem[wb[p].trans_id].issued &&
          mem[wb[p].trans_id].entry.rd == rs) begin
        found    = 1'b1;
        res.data = wb[p].data;
      end
    end

    // x0 reads as not forwarded
    res.valid = found & (|rs);
    return res;
  endfunction

  assign rs1_fwd     = fwd_read(rs1_i, mem_i, wb_i);
  assign rs2_fwd     = fwd_read(rs2_i, mem_i, wb_i);

  assign rs1_o       = rs1_fwd.data;
  assign rs1_valid_o = rs1_fwd.valid;
  assign rs2_o       = rs2_fwd.data;
  assign rs2_valid_o = rs2_fwd.valid;

endmodule

`default_nettype wire

/* scoreboard_top.sv */
// scoreboard top: issue queue, clobber table and operand forwarding

`timescale 1ns/100ps
`default_nettype none

`include "sb_cfg.svh"

module scoreboard_top (
  input  wire logic                                             clk_i,
  input  wire logic                                             rst_ni,
  input  wire logic                                             flush_i,
  output logic                                                  sb_full_o,
  // decoder and issue stage
  input  wire sb_pkg::issue_req_t                               decoded_instr_i,
  output logic                                                  decoded_instr_ack_o,
  output sb_pkg::sb_entry_t                                     issue_instr_o,
  output logic                                                  issue_instr_valid_o,
  input  wire logic                                             issue_ack_i,
  // functional unit results
  input  wire sb_pkg::wb_port_t  [`SB_NR_WB_PORTS-1:0]          wb_i,
  // commit stage
  output sb_pkg::sb_entry_t      [`SB_NR_COMMIT_PORTS-1:0]      commit_instr_o,
  input  wire logic              [`SB_NR_COMMIT_PORTS-1:0]      commit_ack_i,
  // operand read stage
  output sb_pkg::fu_t            [2**`SB_REG_ADDR_BITS-1:0]     rd_clobber_o,
  input  wire sb_pkg::reg_addr_t                                rs1_i,
  output sb_pkg::data_t                                         rs1_o,
  output logic                                                  rs1_valid_o,
  input  wire sb_pkg::reg_addr_t                                rs2_i,
  output sb_pkg::data_t                                         rs2_o,
  output logic                                                  rs2_valid_o
);
  import sb_pkg::*;

  logic                                     issue_en;
  trans_id_t                                issue_ptr;
  trans_id_t [`SB_NR_COMMIT_PORTS-1:0]      commit_ptr;
  sb_slot_t  [`SB_NR_ENTRIES-1:0]           mem;

  // decoded entry tagged with the slot it will land in
  always_comb begin : issue_tag
    issue_instr_o          = decoded_instr_i.entry;
    issue_instr_o.trans_id = issue_ptr;
  end

  // oldest entries towards commit, id is the slot index
  always_comb begin : commit_view
    for (int unsigned k = 0; k < `SB_NR_COMMIT_PORTS; k++) begin
      commit_instr_o[k]          = mem[commit_ptr[k]].entry;
      commit_instr_o[k].trans_id = commit_ptr[k];
    end
  end

  sb_queue_ctrl i_queue_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .dec_valid_i   (decoded_instr_i.valid),
    .issue_ack_i   (issue_ack_i),
    .commit_ack_i  (commit_ack_i),
    .issue_en_o    (issue_en),
    .issue_ptr_o   (issue_ptr),
    .commit_ptr_o  (commit_ptr),
    .full_o        (sb_full_o),
    .issue_valid_o (issue_instr_valid_o),
    .decoded_ack_o (decoded_instr_ack_o)
  );

  sb_entry_store i_entry_store (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .issue_en_i    (issue_en),
    .issue_ptr_i   (issue_ptr),
    .issue_entry_i (issue_instr_o),
    .wb_i          (wb_i),
    .commit_ack_i  (commit_ack_i),
    .commit_ptr_i  (commit_ptr),
    .mem_o         (mem)
  );

  sb_clobber i_clobber (
    .mem_i        (mem),
    .rd_clobber_o (rd_clobber_o)
  );

  sb_operand_fwd i_operand_fwd (
    .mem_i       (mem),
    .wb_i        (wb_i),
    .rs1_i       (rs1_i),
    .rs2_i       (rs2_i),
    .rs1_o       (rs1_o),
    .rs1_valid_o (rs1_valid_o),
    .rs2_o       (rs2_o),
    .rs2_valid_o (rs2_valid_o)
  );

endmodule

`default_nettype wire

/* tb_scoreboard.sv */
// scoreboard testbench: replays per-cycle stimulus from a data file and checks the outputs

`timescale 1ns/100ps
`default_nettype none

`include "sb_cfg.svh"

module tb_scoreboard;
  import sb_pkg::*;

  // --------------------
  // run parameters
  // --------------------
  localparam int unsigned clk_period   = 8;
  localparam int unsigned reset_cycles = 5;
  // spare cycles past the last data row before the watchdog fires
  localparam int unsigned slack_cycles = 20;

  // data file columns, inputs first
  localparam int unsigned nr_cols   = 24;
  localparam int unsigned col_dv    = 0;
  localparam int unsigned col_iack  = 1;
  localparam int unsigned col_fu    = 2;
  localparam int unsigned col_rd    = 3;
  // wb port p uses valid, id, data at col_w0v + 3*p
  localparam int unsigned col_w0v   = 4;
  localparam int unsigned col_cack  = 10;
  localparam int unsigned col_flush = 11;
  localparam int unsigned col_rs1   = 12;
  localparam int unsigned col_creg  = 13;
  // expected outputs
  localparam int unsigned col_ack   = 14;
  localparam int unsigned col_iid   = 15;
  localparam int unsigned col_full  = 16;
  localparam int unsigned col_c0v   = 17;
  localparam int unsigned col_c0id  = 18;
  localparam int unsigned col_c1v   = 19;
  localparam int unsigned col_c1id  = 20;
  localparam int unsigned col_clob  = 21;
  localparam int unsigned col_rsd   = 22;
  localparam int unsigned col_rsv   = 23;

  // --------------------
  // DUT signals
  // --------------------
  logic                                   clk_i;
  logic                                   rst_ni;
  logic                                   flush_i;
  logic                                   sb_full;
  issue_req_t                             decoded_instr;
  logic                                   decoded_instr_ack;
  sb_entry_t                              issue_instr;
  logic                                   issue_instr_valid;
  logic                                   issue_ack;
  wb_port_t  [`SB_NR_WB_PORTS-1:0]        wb;
  sb_entry_t [`SB_NR_COMMIT_PORTS-1:0]    commit_instr;
  logic      [`SB_NR_COMMIT_PORTS-1:0]    commit_ack;
  fu_t       [2**`SB_REG_ADDR_BITS-1:0]   rd_clobber;
  reg_addr_t                              rs1;
  reg_addr_t                              rs2;
  data_t                                  rs1_data;
  data_t                                  rs2_data;
  logic                                   rs1_valid;
  logic                                   rs2_valid;

  // flattened table, one entry per field, row-major
  logic [31:0] cell_val[$];
  bit          cell_dc[$];
  int unsigned nr_rows;
  int unsigned cycle_limit;
  int unsigned cycle_cnt;
  int unsigned err_cnt;

  scoreboard_top scoreboard_top_i (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .flush_i             (flush_i),
    .sb_full_o           (sb_full),
    .decoded_instr_i     (decoded_instr),
    .decoded_instr_ack_o (decoded_instr_ack),
    .issue_instr_o       (issue_instr),
    .issue_instr_valid_o (issue_instr_valid),
    .issue_ack_i         (issue_ack),
    .wb_i                (wb),
    .commit_instr_o      (commit_instr),
    .commit_ack_i        (commit_ack),
    .rd_clobber_o        (rd_clobber),
    .rs1_i               (rs1),
    .rs1_o               (rs1_data),
    .rs1_valid_o         (rs1_valid),
    .rs2_i               (rs2),
    .rs2_o               (rs2_data),
    .rs2_valid_o         (rs2_valid)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever begin
      #(clk_period / 2) clk_i = ~clk_i;
    end
  end

  // stops a run that never reaches its end
  initial begin : watchdog
    wait (cycle_limit != 0);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout: run still busy after %0d cycles", cycle_cnt);
    $display("Test failed");
    $finish;
  end

  // --------------------
  // data file reader
  // --------------------
  // whitespace separated hex fields, x marks a don't-care, // starts a comment line
  task automatic load_testdata();
    int          fd;
    int          lineno;
    int          start;
    int          i;
    string       line;
    string       toks[$];
    fd     = $fopen("sb_testdata.txt", "r");
    lineno = 0;
    if (fd == 0) begin
      $display("could not open stimulus file sb_testdata.txt");
      err_cnt++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      lineno++;
      toks.delete();
      start = -1;
      for (i = 0; i < line.len(); i++) begin
        if (line[i] == " " || line[i] == "\t" || line[i] == "\n" || line[i] == "\r") begin
          if (start >= 0) begin
            toks.push_back(line.substr(start, i - 1));
          end
          start = -1;
        end else if (start < 0) begin
          start = i;
        end
      end
      if (start >= 0) begin
        toks.push_back(line.substr(start, line.len() - 1));
      end
      // blank or comment line
      if (toks.size() == 0 || toks[0].substr(0, 1) == "//") begin
        continue;
      end
      if (toks.size() != nr_cols) begin
        $display("line %0d of sb_testdata.txt has %0d fields instead of %0d",
                 lineno, toks.size(), nr_cols);
        err_cnt++;
        continue;
      end
      foreach (toks[k]) begin
        cell_dc.push_back(toks[k] == "x");
        cell_val.push_back(toks[k] == "x" ? 32'h0 : toks[k].atohex());
      end
    end
    $fclose(fd);
    nr_rows = cell_val.size() / nr_cols;
  endtask

  // --------------------
  // drive and check
  // --------------------
  task automatic apply_inputs(input int unsigned row);
    logic [31:0] v [nr_cols];
    int unsigned c;
    int unsigned p;
    for (c = 0; c < nr_cols; c++) begin
      v[c] = cell_val[row * nr_cols + c];
    end
    decoded_instr             = '0;
    decoded_instr.valid       = v[col_dv][0];
    decoded_instr.entry.fu    = fu_t'(v[col_fu][2:0]);
    decoded_instr.entry.rd    = reg_addr_t'(v[col_rd]);
    issue_ack                 = v[col_iack][0];
    for (p = 0; p < `SB_NR_WB_PORTS; p++) begin
      wb[p].valid    = v[col_w0v + 3 * p][0];
      wb[p].trans_id = trans_id_t'(v[col_w0v + 3 * p + 1]);
      wb[p].data     = v[col_w0v + 3 * p + 2];
    end
    commit_ack = v[col_cack][`SB_NR_COMMIT_PORTS-1:0];
    flush_i    = v[col_flush][0];
    rs1        = reg_addr_t'(v[col_rs1]);
    // both read ports look at the same register, so they share expected columns
    rs2        = reg_addr_t'(v[col_rs1]);
  endtask

  // compares one output against an expected value
  task automatic compare_value(input int unsigned row, input string name,
                               input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else begin
        err_cnt++;
        $display("Fail at %0t: row %0d %s is %0h, expected %0h",
                 $time, row, name, got, exp);
      end
  endtask

  // compares one output against its table entry, skipped on don't-care
  task automatic check_field(input int unsigned row, input int unsigned col,
                             input string name, input logic [31:0] got);
    if (!cell_dc[row * nr_cols + col]) begin
      compare_value(row, name, got, cell_val[row * nr_cols + col]);
    end
  endtask

  task automatic check_outputs(input int unsigned row);
    reg_addr_t   creg;
    int unsigned base;
    logic [31:0] exp_iv;
    base = row * nr_cols;
    creg = reg_addr_t'(cell_val[base + col_creg]);
    check_field(row, col_ack, "decoded_instr_ack_o", 32'(decoded_instr_ack));
    check_field(row, col_iid, "issue trans_id", 32'(issue_instr.trans_id));
    check_field(row, col_full, "sb_full_o", 32'(sb_full));
    check_field(row, col_c0v, "commit 0 valid", 32'(commit_instr[0].valid));
    check_field(row, col_c0id, "commit 0 trans_id", 32'(commit_instr[0].trans_id));
    check_field(row, col_c1v, "commit 1 valid", 32'(commit_instr[1].valid));
    check_field(row, col_c1id, "commit 1 trans_id", 32'(commit_instr[1].trans_id));
    check_field(row, col_clob, "rd_clobber_o", 32'(rd_clobber[creg]));
    check_field(row, col_rsd, "rs1_o", rs1_data);
    check_field(row, col_rsv, "rs1_valid_o", 32'(rs1_valid));
    check_field(row, col_rsd, "rs2_o", rs2_data);
    check_field(row, col_rsv, "rs2_valid_o", 32'(rs2_valid));
    // decoder valid passes to the issue stage only while there is room
    if (!cell_dc[base + col_full]) begin
      exp_iv = 32'(cell_val[base + col_dv][0] & ~cell_val[base + col_full][0]);
      compare_value(row, "issue_instr_valid_o", 32'(issue_instr_valid), exp_iv);
    end
    // decoded fields pass through unchanged
    compare_value(row, "issue fu", 32'(issue_instr.fu), 32'(cell_val[base + col_fu][2:0]));
    compare_value(row, "issue rd", 32'(issue_instr.rd), 32'(cell_val[base + col_rd][4:0]));
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin : stimulus
    int unsigned row;
    rst_ni        = 1'b0;
    flush_i       = 1'b0;
    decoded_instr = '0;
    issue_ack     = 1'b0;
    wb            = '0;
    commit_ack    = '0;
    rs1           = '0;
    rs2           = '0;
    err_cnt       = 0;
    cycle_cnt     = 0;
    cycle_limit   = 0;
    nr_rows       = 0;
    load_testdata();
    cycle_limit = nr_rows + reset_cycles + slack_cycles;

    repeat (reset_cycles) @(posedge clk_i);
    #1 rst_ni = 1'b1;

    // inputs 1 ns after the edge, outputs sampled 1 ns before the next one
    for (row = 0; row < nr_rows; row++) begin
      @(posedge clk_i);
      #1 apply_inputs(row);
      #(clk_period - 2) check_outputs(row);
    end

    $display("%0d rows checked, %0d errors", nr_rows, err_cnt);
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sb_testdata.txt */
// in (hex): dv iack fu rd  wb0 v id data  wb1 v id data  cack flush rs1 clob_reg
// expected: ack iss_id full  c0v c0id c1v c1id  clob_fu rs1_data rs1_valid  (x = don't care)
1 1 1 01  0 0 00000000  0 0 00000000  0 0 01 01   1 0 0  0 0 0 1  0 00000000 0
1 1 3 02  0 0 00000000  0 0 00000000  0 0 01 01   1 1 0  0 0 0 1  1 00000000 0
1 1 5 09  0 0 00000000  0 0 00000000  0 0 02 02   1 2 0  0 0 0 1  3 00000000 0
1 1 1 09  0 0 00000000  0 0 00000000  0 0 09 09   1 3 0  0 0 0 1  5 00000000 0
1 1 6 09  0 0 00000000  0 0 00000000  0 0 09 09   1 4 0  0 0 0 1  5 00000000 0
1 1 4 00  0 0 00000000  0 0 00000000  0 0 09 00   1 5 0  0 0 0 1  0 00000000 0
1 1 2 0a  0 0 00000000  0 0 00000000  0 0 00 00   1 6 0  0 0 0 1  0 00000000 0
1 1 1 0b  0 0 00000000  0 0 00000000  0 0 02 0a   0 7 1  0 0 0 1  2 00000000 0
0 1 0 00  1 1 11110001  0 0 00000000  0 0 02 02   0 7 1  0 0 0 1  3 11110001 1
0 1 0 00  1 0 a0a0a0a0  0 0 00000000  0 0 02 01   0 7 1  0 0 1 1  1 11110001 1
0 1 0 00  0 0 00000000  0 0 00000000  3 0 01 01   0 7 1  1 0 1 1  1 a0a0a0a0 1
0 1 0 00  0 0 00000000  0 0 00000000  0 0 01 01   1 7 0  0 2 0 3  0 00000000 0
1 1 0 0c  0 0 00000000  0 0 00000000  0 0 02 02   1 7 0  0 2 0 3  0 00000000 0
0 1 0 00  1 4 44444444  0 0 00000000  0 0 09 09   1 0 0  0 2 0 3  5 44444444 1
0 1 0 00  1 2 22222222  1 3 33333333  0 0 09 0c   1 0 0  0 2 0 3  0 22222222 1
0 1 0 00  0 0 00000000  0 0 00000000  3 0 09 09   1 0 0  1 2 1 3  5 22222222 1
0 1 0 00  0 0 00000000  0 0 00000000  1 0 09 09   1 0 0  1 4 0 5  6 44444444 1
0 1 0 00  1 5 55555555  0 0 00000000  0 0 00 00   1 0 0  0 5 0 6  0 x 0
0 1 0 00  1 6 66666666  0 0 00000000  1 0 0a 0a   1 0 0  1 5 0 6  2 66666666 1
0 1 0 00  0 0 00000000  0 0 00000000  3 0 0c 0a   1 0 0  1 6 1 7  2 00000000 1
1 1 1 0d  0 0 00000000  0 0 00000000  0 0 0c 0a   1 0 0  0 0 0 1  0 00000000 0
1 1 1 0d  0 0 00000000  0 0 00000000  0 0 0d 0d   1 1 0  0 0 0 1  1 00000000 0
1 1 1 0d  1 0 0d0d0d0d  0 0 00000000  0 0 0d 0d   1 2 0  0 0 0 1  1 0d0d0d0d 1
1 1 1 0d  0 0 00000000  0 0 00000000  0 0 0d 0d   1 3 0  1 0 0 1  1 0d0d0d0d 1
1 1 1 0d  0 0 00000000  0 0 00000000  0 0 0d 0d   1 4 0  1 0 0 1  1 0d0d0d0d 1
1 1 1 0d  0 0 00000000  0 0 00000000  0 0 0d 0d   1 5 0  1 0 0 1  1 0d0d0d0d 1
1 1 1 0d  0 0 00000000  0 0 00000000  0 0 0d 0d   1 6 0  1 0 0 1  1 0d0d0d0d 1
1 1 1 0d  0 0 00000000  0 0 00000000  0 0 0d 0d   0 7 1  1 0 0 1  1 0d0d0d0d 1
0 1 0 00  0 0 00000000  0 0 00000000  0 1 0d 0d   0 7 1  1 0 0 1  1 0d0d0d0d 1
1 1 0 0e  0 0 00000000  0 0 00000000  0 0 0d 0d   1 0 0  0 0 0 1  0 00000000 0
0 1 0 00  0 0 00000000  0 0 00000000  0 0 0e 0e   1 1 0  0 0 0 1  0 00000000 0
0 1 0 00  0 0 00000000  0 0 00000000  1 0 0e 0e   1 1 0  1 0 0 1  0 00000000 1
0 1 0 00  0 0 00000000  0 0 00000000  0 0 0e 0d   1 1 0  0 1 0 2  0 00000000 0

/* compile.f */
+incdir+.
sb_pkg.sv
sb_queue_ctrl.sv
sb_entry_store.sv
sb_clobber.sv
sb_operand_fwd.sv
scoreboard_top.sv
tb_scoreboard.sv
